// File: source/frontend_pkg.sv
/* shared front end constants: address width, BTB sizing, request buffer depth
   and the next-PC source enum */

`default_nettype none

package frontend_pkg;

    // ------------------------------------------------------------
    // addressing
    // ------------------------------------------------------------
    // virtual address width, every PC and target uses it
    localparam int unsigned VADDR_WIDTH = 64;

    // ------------------------------------------------------------
    // branch target buffer
    // ------------------------------------------------------------
    // number of direct-mapped entries
    localparam int unsigned BTB_ENTRIES = 16;
    // index is taken from pc[5:2]
    localparam int unsigned BTB_INDEX_BITS = 4;
    // per-entry counter, top bit set means predict taken
    localparam int unsigned SAT_COUNTER_BITS = 2;

    // ------------------------------------------------------------
    // fetch request buffer
    // ------------------------------------------------------------
    // two requests can be in flight towards the fetch side
    localparam int unsigned FETCH_BUF_DEPTH = 2;

    // reason why a fetch address was chosen
    typedef enum logic [2:0] {
        // default PC + 4
        SRC_SEQ        = 3'd0,
        // taken prediction from the BTB
        SRC_PREDICT    = 3'd1,
        // correction after a resolved mispredict
        SRC_MISPREDICT = 3'd2,
        // set-PC request from debug
        SRC_DEBUG      = 3'd3,
        // jump to the trap vector
        SRC_EXCEPTION  = 3'd4,
        // return from exception to epc
        SRC_ERET       = 3'd5,
        // pipeline flush, restart after the committed PC
        SRC_FLUSH      = 3'd6
    } pc_src_e;

endpackage

`default_nettype wire

// File: source/btb.sv
/* direct-mapped branch target buffer with saturating counters,
   combinational lookup, single update port and flush */

`timescale 1ns/1ps
`default_nettype none

module btb
    import frontend_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    // drop all predictions
    input  wire logic                   flush_i,
    // read port
    input  wire logic [VADDR_WIDTH-1:0] lookup_pc_i,
    // update port from resolved branches
    input  wire logic                   update_valid_i,
    input  wire logic [VADDR_WIDTH-1:0] update_pc_i,
    input  wire logic [VADDR_WIDTH-1:0] update_target_i,
    input  wire logic                   update_taken_i,
    // prediction for lookup_pc_i
    output logic                        predict_valid_o,
    output logic                        predict_taken_o,
    output logic [VADDR_WIDTH-1:0]      predict_target_o
);

    // valid bits are control state, the arrays are payload
    logic [BTB_ENTRIES-1:0]      valid_q;
    logic [VADDR_WIDTH-1:0]      tag_q    [BTB_ENTRIES];
    logic [VADDR_WIDTH-1:0]      target_q [BTB_ENTRIES];
    logic [SAT_COUNTER_BITS-1:0] cnt_q    [BTB_ENTRIES];

    logic [BTB_INDEX_BITS-1:0]   lookup_idx;
    logic [BTB_INDEX_BITS-1:0]   update_idx;
    logic                        update_hit;
    logic [SAT_COUNTER_BITS-1:0] update_cnt;

    // index from the word address, pc[5:2]
    assign lookup_idx = lookup_pc_i[BTB_INDEX_BITS+1:2];
    assign update_idx = update_pc_i[BTB_INDEX_BITS+1:2];

    // ------------------------------------------------------------
    // read port
    // ------------------------------------------------------------
    // full PC as tag, so no aliasing between branches
    assign predict_valid_o  = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_pc_i);
    assign predict_taken_o  = predict_valid_o && cnt_q[lookup_idx][SAT_COUNTER_BITS-1];
    assign predict_target_o = target_q[lookup_idx];

    // ------------------------------------------------------------
    // update port
    // ------------------------------------------------------------
    assign update_hit = valid_q[update_idx] && (tag_q[update_idx] == update_pc_i);

    always_comb begin : counter_next
        if (!update_hit) begin
            // fresh install starts weakly in the direction of the outcome
            if (update_taken_i) begin
                update_cnt = {1'b1, {(SAT_COUNTER_BITS-1){1'b0}}};
            end else begin
                update_cnt = {1'b0, {(SAT_COUNTER_BITS-1){1'b1}}};
            end
        end else begin
            update_cnt = cnt_q[update_idx];
            // one step toward the outcome, saturating at both ends
            if (update_taken_i && (cnt_q[update_idx] != {SAT_COUNTER_BITS{1'b1}})) begin
                update_cnt = cnt_q[update_idx] + 1'b1;
            end else if (!update_taken_i && (cnt_q[update_idx] != '0)) begin
                update_cnt = cnt_q[update_idx] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_regs
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // flush wins over a concurrent install
            valid_q <= '0;
        end else if (update_valid_i) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin : entry_regs
        if (update_valid_i) begin
            tag_q[update_idx]    <= update_pc_i;
            target_q[update_idx] <= update_target_i;
            cnt_q[update_idx]    <= update_cnt;
        end
    end

endmodule

`default_nettype wire

// File: source/pcgen_stage.sv
/* PC generation: priority next-PC select, PC register, registered resolve
   input feeding the BTB, and the redirect strobe */

`timescale 1ns/1ps
`default_nettype none

module pcgen_stage
    import frontend_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    // global control
    input  wire logic [VADDR_WIDTH-1:0] boot_addr_i,
    input  wire logic                   fetch_enable_i,
    input  wire logic                   flush_i,
    input  wire logic                   flush_bp_i,
    // from commit and CSR
    input  wire logic [VADDR_WIDTH-1:0] pc_commit_i,
    input  wire logic [VADDR_WIDTH-1:0] epc_i,
    input  wire logic                   eret_i,
    input  wire logic [VADDR_WIDTH-1:0] trap_vector_base_i,
    input  wire logic                   ex_valid_i,
    // debug
    input  wire logic [VADDR_WIDTH-1:0] debug_pc_i,
    input  wire logic                   debug_set_pc_i,
    // resolved branch from execute
    input  wire logic                   resolve_valid_i,
    input  wire logic [VADDR_WIDTH-1:0] resolve_pc_i,
    input  wire logic [VADDR_WIDTH-1:0] resolve_target_i,
    input  wire logic                   resolve_taken_i,
    input  wire logic                   resolve_mispredict_i,
    // request towards the fetch buffer
    input  wire logic                   req_ready_i,
    output logic                        req_valid_o,
    output logic [VADDR_WIDTH-1:0]      req_addr_o,
    output logic                        req_taken_pred_o,
    output pc_src_e                     req_src_o,
    output logic                        redirect_o
);

    // PC register and the source that produced it
    logic [VADDR_WIDTH-1:0] npc_n, npc_q;
    pc_src_e                src_n, src_q;
    // last cycle loaded a debug, exception, eret or flush address
    logic                   set_pc_n, set_pc_q;

    // resolve input register, this path is critical
    logic                   resolve_valid_q;
    logic                   resolve_mispredict_q;
    logic [VADDR_WIDTH-1:0] resolve_pc_q;
    logic [VADDR_WIDTH-1:0] resolve_target_q;
    logic                   resolve_taken_q;

    logic                   predict_valid;
    logic                   predict_taken;
    logic [VADDR_WIDTH-1:0] predict_target;

    logic                   correct;
    logic                   bp_taken;
    logic                   req_accept;
    logic [VADDR_WIDTH-1:0] fetch_addr;
    pc_src_e                fetch_src;

    // lookup with the PC register, update with last cycle's resolve
    btb i_btb (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_bp_i),
        .lookup_pc_i      (npc_q),
        .update_valid_i   (resolve_valid_q),
        .update_pc_i      (resolve_pc_q),
        .update_target_i  (resolve_target_q),
        .update_taken_i   (resolve_taken_q),
        .predict_valid_o  (predict_valid),
        .predict_taken_o  (predict_taken),
        .predict_target_o (predict_target)
    );

    // ------------------------------------------------------------
    // current fetch address
    // ------------------------------------------------------------
    // mispredict correction, skipped right after a redirect
    assign correct    = resolve_mispredict_q && !set_pc_q;
    assign fetch_addr = correct ? resolve_target_q : npc_q;
    assign fetch_src  = correct ? SRC_MISPREDICT : src_q;

    // BTB answer belongs to npc_q, not to a corrected address
    assign bp_taken   = predict_valid && predict_taken && !correct;

    assign req_valid_o = fetch_enable_i;
    assign req_addr_o  = fetch_addr;
    assign req_src_o   = fetch_src;
    assign req_accept  = req_valid_o && req_ready_i;
    assign redirect_o  = set_pc_q;

    // ------------------------------------------------------------
    // next PC, lowest priority first
    // ------------------------------------------------------------
    always_comb begin : npc_select
        // hold the current address while not accepted
        npc_n            = fetch_addr;
        src_n            = fetch_src;
        set_pc_n         = 1'b0;
        // follow a prediction only on a word aligned fetch
        req_taken_pred_o = bp_taken && !fetch_addr[1];

        if (req_accept) begin
            npc_n = {fetch_addr[VADDR_WIDTH-1:2], 2'b00} + VADDR_WIDTH'(4);
            src_n = SRC_SEQ;
            if (bp_taken && !fetch_addr[1]) begin
                npc_n = predict_target;
                src_n = SRC_PREDICT;
            end
        end

        if (debug_set_pc_i) begin
            npc_n    = debug_pc_i;
            src_n    = SRC_DEBUG;
            set_pc_n = 1'b1;
        end

        if (ex_valid_i) begin
            npc_n            = trap_vector_base_i;
            src_n            = SRC_EXCEPTION;
            set_pc_n         = 1'b1;
            req_taken_pred_o = 1'b0;
        end

        if (eret_i) begin
            npc_n    = epc_i;
            src_n    = SRC_ERET;
            set_pc_n = 1'b1;
        end

        // CSR side effects, restart after the committed instruction
        if (flush_i) begin
            npc_n    = pc_commit_i + VADDR_WIDTH'(4);
            src_n    = SRC_FLUSH;
            set_pc_n = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : pc_regs
        if (!rst_ni) begin
            npc_q                <= boot_addr_i;
            src_q                <= SRC_SEQ;
            set_pc_q             <= 1'b0;
            resolve_valid_q      <= 1'b0;
            resolve_mispredict_q <= 1'b0;
        end else begin
            npc_q                <= npc_n;
            src_q                <= src_n;
            set_pc_q             <= set_pc_n;
            resolve_valid_q      <= resolve_valid_i;
            resolve_mispredict_q <= resolve_valid_i && resolve_mispredict_i;
        end
    end

    always_ff @(posedge clk_i) begin : resolve_payload
        resolve_pc_q     <= resolve_pc_i;
        resolve_target_q <= resolve_target_i;
        resolve_taken_q  <= resolve_taken_i;
    end

endmodule

`default_nettype wire

// File: source/fetch_buffer.sv
/* two-entry fetch request queue with valid/ready on both sides,
   emptied by a redirect clear */

`timescale 1ns/1ps
`default_nettype none

module fetch_buffer
    import frontend_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    // drop everything held, a push in the same cycle survives
    input  wire logic                   clear_i,
    // write side from the PC stage
    input  wire logic                   push_valid_i,
    input  wire logic [VADDR_WIDTH-1:0] push_addr_i,
    input  wire logic                   push_pred_i,
    input  wire pc_src_e                push_src_i,
    output logic                        push_ready_o,
    // read side towards fetch
    input  wire logic                   pop_ready_i,
    output logic                        pop_valid_o,
    output logic [VADDR_WIDTH-1:0]      pop_addr_o,
    output logic                        pop_pred_o,
    output pc_src_e                     pop_src_o
);

    // request storage
    logic [VADDR_WIDTH-1:0]             addr_q [FETCH_BUF_DEPTH];
    logic                               pred_q [FETCH_BUF_DEPTH];
    pc_src_e                            src_q  [FETCH_BUF_DEPTH];

    logic [$clog2(FETCH_BUF_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
    logic [$clog2(FETCH_BUF_DEPTH+1)-1:0] count_q;

    logic                               push_acc;
    logic                               pop_acc;

    // a clear frees the whole buffer for the incoming redirect address
    assign push_ready_o = (count_q < FETCH_BUF_DEPTH) || clear_i;
    // stale entries never leave during a clear
    assign pop_valid_o  = (count_q != '0) && !clear_i;

    assign push_acc = push_valid_i && push_ready_o;
    assign pop_acc  = pop_valid_o && pop_ready_i;

    assign pop_addr_o = addr_q[rd_ptr_q];
    assign pop_pred_o = pred_q[rd_ptr_q];
    assign pop_src_o  = src_q[rd_ptr_q];

    // ------------------------------------------------------------
    // pointers and fill count
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_regs
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + push_acc;
            if (clear_i) begin
                // read pointer jumps to the write slot
                rd_ptr_q <= wr_ptr_q;
                count_q  <= push_acc;
            end else begin
                rd_ptr_q <= rd_ptr_q + pop_acc;
                count_q  <= count_q + push_acc - pop_acc;
            end
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        if (push_acc) begin
            addr_q[wr_ptr_q] <= push_addr_i;
            pred_q[wr_ptr_q] <= push_pred_i;
            src_q[wr_ptr_q]  <= push_src_i;
        end
    end

endmodule

`default_nettype wire

// File: source/frontend_top.sv
/* instruction front end top: PC stage with BTB feeding the fetch buffer */

`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import frontend_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic [VADDR_WIDTH-1:0] boot_addr_i,
    input  wire logic                   fetch_enable_i,
    input  wire logic                   flush_i,
    input  wire logic                   flush_bp_i,
    input  wire logic [VADDR_WIDTH-1:0] pc_commit_i,
    input  wire logic [VADDR_WIDTH-1:0] epc_i,
    input  wire logic                   eret_i,
    input  wire logic [VADDR_WIDTH-1:0] trap_vector_base_i,
    input  wire logic                   ex_valid_i,
    input  wire logic [VADDR_WIDTH-1:0] debug_pc_i,
    input  wire logic                   debug_set_pc_i,
    // resolved branch
    input  wire logic                   resolve_valid_i,
    input  wire logic [VADDR_WIDTH-1:0] resolve_pc_i,
    input  wire logic [VADDR_WIDTH-1:0] resolve_target_i,
    input  wire logic                   resolve_taken_i,
    input  wire logic                   resolve_mispredict_i,
    // fetch request port
    input  wire logic                   fetch_ready_i,
    output logic                        fetch_valid_o,
    output logic [VADDR_WIDTH-1:0]      fetch_addr_o,
    output logic                        fetch_pred_taken_o,
    output pc_src_e                     fetch_src_o
);

    // stage to buffer
    logic                   req_valid;
    logic                   req_ready;
    logic [VADDR_WIDTH-1:0] req_addr;
    logic                   req_taken_pred;
    pc_src_e                req_src;
    logic                   redirect;

    pcgen_stage i_pcgen_stage (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .boot_addr_i          (boot_addr_i),
        .fetch_enable_i       (fetch_enable_i),
        .flush_i              (flush_i),
        .flush_bp_i           (flush_bp_i),
        .pc_commit_i          (pc_commit_i),
        .epc_i                (epc_i),
        .eret_i               (eret_i),
        .trap_vector_base_i   (trap_vector_base_i),
        .ex_valid_i           (ex_valid_i),
        .debug_pc_i           (debug_pc_i),
        .debug_set_pc_i       (debug_set_pc_i),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_pc_i         (resolve_pc_i),
        .resolve_target_i     (resolve_target_i),
        .resolve_taken_i      (resolve_taken_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .req_ready_i          (req_ready),
        .req_valid_o          (req_valid),
        .req_addr_o           (req_addr),
        .req_taken_pred_o     (req_taken_pred),
        .req_src_o            (req_src),
        .redirect_o           (redirect)
    );

    // redirect empties whatever was queued before it
    fetch_buffer i_fetch_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (redirect),
        .push_valid_i (req_valid),
        .push_addr_i  (req_addr),
        .push_pred_i  (req_taken_pred),
        .push_src_i   (req_src),
        .push_ready_o (req_ready),
        .pop_ready_i  (fetch_ready_i),
        .pop_valid_o  (fetch_valid_o),
        .pop_addr_o   (fetch_addr_o),
        .pop_pred_o   (fetch_pred_taken_o),
        .pop_src_o    (fetch_src_o)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
/* testbench clock (20 ns period) and active low reset held for 5 cycles */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin : clock_loop
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // release right after the fifth rising edge
    initial begin : reset_seq
        rst_no = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/frontend_tb.sv
/* front end testbench: replays stimulus records from the data file and checks
   every accepted fetch request against the expected request queue */

`timescale 1ns/1ps
`default_nettype none

module frontend_tb
    import frontend_pkg::*;
();

    localparam int MAX_STIM = 64;
    localparam logic [VADDR_WIDTH-1:0] BOOT_ADDR  = 64'h0000_0000_8000_0000;
    localparam logic [VADDR_WIDTH-1:0] TRAP_BASE  = 64'h0000_0000_0000_0100;
    localparam logic [VADDR_WIDTH-1:0] EPC_ADDR   = 64'h0000_0000_0000_2000;
    localparam logic [VADDR_WIDTH-1:0] COMMIT_PC  = 64'h0000_0000_0000_4000;

    logic                   clk;
    logic                   rst_n;
    logic                   fetch_enable;
    logic                   flush;
    logic                   flush_bp;
    logic                   ex_valid;
    logic                   eret;
    logic                   debug_set_pc;
    logic [VADDR_WIDTH-1:0] debug_pc;
    logic                   resolve_valid;
    logic [VADDR_WIDTH-1:0] resolve_pc;
    logic [VADDR_WIDTH-1:0] resolve_target;
    logic                   resolve_taken;
    logic                   resolve_mispredict;
    logic                   fetch_ready;
    logic                   fetch_valid;
    logic [VADDR_WIDTH-1:0] fetch_addr;
    logic                   fetch_pred_taken;
    pc_src_e                fetch_src;

    // stimulus table, flags packed as {en, flush, fbp, ex, eret, dbg, rv, rt, rm}
    int                     stim_delay [MAX_STIM];
    int                     stim_mode  [MAX_STIM];
    logic [8:0]             stim_flags [MAX_STIM];
    logic [VADDR_WIDTH-1:0] stim_dpc   [MAX_STIM];
    logic [VADDR_WIDTH-1:0] stim_rpc   [MAX_STIM];
    logic [VADDR_WIDTH-1:0] stim_rtgt  [MAX_STIM];
    int                     stim_count;

    // expected requests in output order
    logic [VADDR_WIDTH-1:0] exp_addr_q [$];
    logic                   exp_pred_q [$];
    int                     exp_src_q  [$];

    // ready mode: 0 random, 1 always high, 2 always low
    int                     ready_mode;
    int                     cycle_count;
    int                     cycle_limit;
    bit                     limit_set;

    tb_clock_gen i_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    frontend_top DUT (
        .clk_i                (clk),
        .rst_ni               (rst_n),
        .boot_addr_i          (BOOT_ADDR),
        .fetch_enable_i       (fetch_enable),
        .flush_i              (flush),
        .flush_bp_i           (flush_bp),
        .pc_commit_i          (COMMIT_PC),
        .epc_i                (EPC_ADDR),
        .eret_i               (eret),
        .trap_vector_base_i   (TRAP_BASE),
        .ex_valid_i           (ex_valid),
        .debug_pc_i           (debug_pc),
        .debug_set_pc_i       (debug_set_pc),
        .resolve_valid_i      (resolve_valid),
        .resolve_pc_i         (resolve_pc),
        .resolve_target_i     (resolve_target),
        .resolve_taken_i      (resolve_taken),
        .resolve_mispredict_i (resolve_mispredict),
        .fetch_ready_i        (fetch_ready),
        .fetch_valid_o        (fetch_valid),
        .fetch_addr_o         (fetch_addr),
        .fetch_pred_taken_o   (fetch_pred_taken),
        .fetch_src_o          (fetch_src)
    );

    // ------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------
    task automatic end_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    // ------------------------------------------------------------
    // data file
    // ------------------------------------------------------------
    task automatic read_data_file();
        int fd;
        int n;
        string line;
        int d, m, en, fl, fbp, ex, er, dbg, rv, rt, rm, pred, src;
        logic [63:0] dpc, rpc, rtgt, addr;
        fd = $fopen("test/frontend_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            end_with_failure();
        end else begin
            stim_count = 0;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line.getc(0) == "S") begin
                    n = $sscanf(line, "S %d %d %d %d %d %d %d %d %d %d %d %h %h %h",
                        d, m, en, fl, fbp, ex, er, dbg, rv, rt, rm, dpc, rpc, rtgt);
                    if (n != 14 || stim_count >= MAX_STIM) begin
                        $display("a stimulus record is malformed or the table is full");
                        end_with_failure();
                    end else begin
                        stim_delay[stim_count] = d;
                        stim_mode[stim_count]  = m;
                        stim_flags[stim_count] = {en[0], fl[0], fbp[0], ex[0], er[0],
                                                  dbg[0], rv[0], rt[0], rm[0]};
                        stim_dpc[stim_count]   = dpc;
                        stim_rpc[stim_count]   = rpc;
                        stim_rtgt[stim_count]  = rtgt;
                        stim_count++;
                    end
                end else if (n > 0 && line.len() > 0 && line.getc(0) == "E") begin
                    n = $sscanf(line, "E %h %d %d", addr, pred, src);
                    if (n != 3) begin
                        $display("an expect record in the data file is malformed");
                        end_with_failure();
                    end else begin
                        exp_addr_q.push_back(addr);
                        exp_pred_q.push_back(pred[0]);
                        exp_src_q.push_back(src);
                    end
                end
            end
            $fclose(fd);
            // generous budget per record on top of reset and drain time
            cycle_limit = 200 + 20 * (stim_count + exp_addr_q.size());
            limit_set   = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic drive_ready();
        if (ready_mode == 0) begin
            fetch_ready <= ($urandom % 2) != 0;
        end else begin
            fetch_ready <= (ready_mode == 1);
        end
    endtask

    task automatic apply_record(int i);
        ready_mode         = stim_mode[i];
        fetch_enable       <= stim_flags[i][8];
        flush              <= stim_flags[i][7];
        flush_bp           <= stim_flags[i][6];
        ex_valid           <= stim_flags[i][5];
        eret               <= stim_flags[i][4];
        debug_set_pc       <= stim_flags[i][3];
        resolve_valid      <= stim_flags[i][2];
        resolve_taken      <= stim_flags[i][1];
        resolve_mispredict <= stim_flags[i][0];
        debug_pc           <= stim_dpc[i];
        resolve_pc         <= stim_rpc[i];
        resolve_target     <= stim_rtgt[i];
    endtask

    initial begin : main_seq
        void'($urandom(32'hf8ef721d));
        fetch_enable       = 1'b0;
        flush              = 1'b0;
        flush_bp           = 1'b0;
        ex_valid           = 1'b0;
        eret               = 1'b0;
        debug_set_pc       = 1'b0;
        debug_pc           = '0;
        resolve_valid      = 1'b0;
        resolve_pc         = '0;
        resolve_target     = '0;
        resolve_taken      = 1'b0;
        resolve_mispredict = 1'b0;
        fetch_ready        = 1'b0;
        ready_mode         = 1;
        read_data_file();

        @(posedge rst_n);
        // delays count rising edges from the previous record
        for (int i = 0; i < stim_count; i++) begin
            repeat (stim_delay[i] - 1) begin
                @(posedge clk);
                drive_ready();
            end
            @(posedge clk);
            apply_record(i);
            drive_ready();
        end

        while (exp_addr_q.size() != 0) begin
            @(posedge clk);
            drive_ready();
        end
        // a few idle cycles catch any request that should not exist
        repeat (8) begin
            @(posedge clk);
            drive_ready();
        end
        $display("All checks passed");
        $finish;
    end

    // ------------------------------------------------------------
    // output check, sampled mid cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin : output_monitor
        if (rst_n && fetch_valid && fetch_ready) begin
            if (exp_addr_q.size() == 0) begin
                $display("a fetch request appeared when none was expected");
                end_with_failure();
            end else begin
                check_value("fetch_addr_o", fetch_addr, exp_addr_q.pop_front());
                check_value("fetch_pred_taken_o", 64'(fetch_pred_taken),
                            64'(exp_pred_q.pop_front()));
                check_value("fetch_src_o", 64'(fetch_src), 64'(exp_src_q.pop_front()));
            end
        end
    end

    always @(posedge clk) begin : timeout_watch
        cycle_count++;
        if (limit_set && cycle_count > cycle_limit) begin
            $display("simulation timed out before all requests were seen");
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: project.f
source/frontend_pkg.sv
source/btb.sv
source/pcgen_stage.sv
source/fetch_buffer.sv
source/frontend_top.sv
test/tb_clock_gen.sv
test/frontend_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the front end testbench, exit status is the simulation result
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f project.f \
        --top-module frontend_tb -o frontend_sim \
    && ./obj_dir/frontend_sim \
    || exit 1

// File: test/frontend_testdata.txt
# S delay mode en flush flush_bp ex eret dbg rv rt rm debug_pc resolve_pc resolve_target
# E addr pred src   (src 0 seq, 1 predict, 2 mispredict, 3 debug, 4 exception, 5 eret, 6 flush)
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 4 2 1 0 0 0 0 0 0 0 0 0 0 0
S 7 0 0 0 0 0 0 0 0 0 0 0 0 0
S 16 1 1 0 0 0 0 0 0 0 0 0 0 0
S 2 2 1 0 0 0 0 0 0 0 0 0 0 0
S 2 2 1 0 0 1 0 0 0 0 0 0 0 0
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 3 1 1 0 0 1 1 1 0 0 0 3000 0 0
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 3 1 1 1 0 1 0 0 0 0 0 0 0 0
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 2 1 1 0 0 0 0 1 0 0 0 3000 0 0
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 2 1 0 0 0 0 0 0 0 0 0 0 0 0
S 4 1 0 0 0 0 0 0 1 1 0 0 5010 6000
S 1 1 0 0 0 0 0 0 1 1 0 0 5010 6000
S 1 1 0 0 0 0 0 0 0 0 0 0 0 0
S 3 1 1 0 0 0 0 1 0 0 0 5008 0 0
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 5 1 0 0 1 0 0 0 0 0 0 0 0 0
S 1 1 0 0 0 0 0 0 0 0 0 0 0 0
S 2 1 1 0 0 0 0 1 0 0 0 500c 0 0
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 3 1 0 0 0 0 0 0 1 1 0 0 7002 7100
S 1 1 0 0 0 0 0 0 0 0 0 0 0 0
S 3 1 1 0 0 0 0 1 0 0 0 7002 0 0
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 2 1 1 0 0 0 0 0 1 1 1 0 8020 9000
S 1 1 1 0 0 0 0 0 0 0 0 0 0 0
S 2 1 0 0 0 0 0 0 0 0 0 0 0 0
E 80000000 0 0
E 80000004 0 0
E 80000008 0 0
E 8000000c 0 0
E 80000010 0 0
E 80000014 0 0
E 100 0 4
E 104 0 0
E 108 0 0
E 2000 0 5
E 2004 0 0
E 2008 0 0
E 4004 0 6
E 4008 0 0
E 3000 0 3
E 3004 0 0
E 5008 0 3
E 500c 0 0
E 5010 1 0
E 6000 0 1
E 6004 0 0
E 500c 0 3
E 5010 0 0
E 5014 0 0
E 7002 0 3
E 7004 0 0
E 7008 0 0
E 9000 0 2
E 9004 0 0
